// ==== design/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath word width
`define XLEN 32

// architectural register count
`define NUM_REGS 32

// enough bits to index every register
`define REG_AW 5

// fixed MIPS-style instruction word
`define INST_W 32

// value of every register after reset, also what r0 reads as
`define ZERO_WORD {`XLEN{1'b0}}

`endif

// ==== design/decode_stage.sv ====
`default_nettype none

`include "core_config.svh"

module decode_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire logic               inst_valid_i,
	input  wire inst_fields_t       inst_i,
	// register file read data
	input  wire logic [`XLEN-1:0]   rs_data_i,
	input  wire logic [`XLEN-1:0]   rt_data_i,
	// bypass sources, execute has priority
	input  wire wb_t                ex_fwd_i,
	input  wire wb_t                wb_fwd_i,
	output logic      [`REG_AW-1:0] rs_addr_o,
	output logic      [`REG_AW-1:0] rt_addr_o,
	output id_ex_t                  id_ex_o
);

	logic [15:0]        imm16;
	logic [`XLEN-1:0]   imm_zext;
	logic [`XLEN-1:0]   imm_sext;
	logic [`XLEN-1:0]   rs_val;
	logic [`XLEN-1:0]   rt_val;
	alu_op_e            alu_op;
	logic [`REG_AW-1:0] dest;
	logic [`XLEN-1:0]   op_a;
	logic [`XLEN-1:0]   op_b;
	logic               wen;

	// youngest matching writer wins
	// r0 never matches, its writers have wen low
	function automatic logic [`XLEN-1:0] bypass(
		input logic [`REG_AW-1:0] addr,
		input logic [`XLEN-1:0]   rf_data,
		input wb_t                ex_src,
		input wb_t                wb_src
	);
		if (ex_src.wen && (ex_src.dest == addr)) begin
			return ex_src.data;
		end else if (wb_src.wen && (wb_src.dest == addr)) begin
			return wb_src.data;
		end
		return rf_data;
	endfunction

	// both sources always read, unused one is ignored
	assign rs_addr_o = inst_i.rs;
	assign rt_addr_o = inst_i.rt;

	assign rs_val = bypass(inst_i.rs, rs_data_i, ex_fwd_i, wb_fwd_i);
	assign rt_val = bypass(inst_i.rt, rt_data_i, ex_fwd_i, wb_fwd_i);

	// immediate sits in the low half
	assign imm16    = {inst_i.rd, inst_i.sa, inst_i.funct};
	assign imm_zext = `XLEN'(imm16);
	assign imm_sext = `XLEN'(signed'(imm16));

	always_comb begin
		// unknown codes fall out as ALU_NOP
		alu_op = ALU_NOP;
		dest   = inst_i.rt;
		op_a   = rs_val;
		op_b   = imm_zext;
		case (inst_i.opcode)
			OP_ORI: begin
				alu_op = ALU_ORI;
			end
			OP_ANDI: begin
				alu_op = ALU_ANDI;
			end
			OP_XORI: begin
				alu_op = ALU_XORI;
			end
			OP_LUI: begin
				// no source, only the immediate
				alu_op = ALU_LUI;
				op_a   = `ZERO_WORD;
			end
			OP_ADDI: begin
				alu_op = ALU_ADDI;
				op_b   = imm_sext;
			end
			OP_ADDIU: begin
				alu_op = ALU_ADDIU;
				op_b   = imm_sext;
			end
			OP_SLTIU: begin
				// sign-extended, then compared unsigned
				alu_op = ALU_SLTIU;
				op_b   = imm_sext;
			end
			OP_SPECIAL: begin
				dest = inst_i.rd;
				op_b = rt_val;
				case (inst_i.funct)
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_NOR: alu_op = ALU_NOR;
					FN_ADD: alu_op = ALU_ADD;
					FN_ADDU: alu_op = ALU_ADDU;
					FN_SUB: alu_op = ALU_SUB;
					FN_SUBU: alu_op = ALU_SUBU;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_SLLV: alu_op = ALU_SLLV;
					FN_SRLV: alu_op = ALU_SRLV;
					FN_SRAV: alu_op = ALU_SRAV;
					// fixed shifts carry sa in operand a
					FN_SLL: begin
						alu_op = ALU_SLL;
						op_a   = `XLEN'(inst_i.sa);
					end
					FN_SRL: begin
						alu_op = ALU_SRL;
						op_a   = `XLEN'(inst_i.sa);
					end
					FN_SRA: begin
						alu_op = ALU_SRA;
						op_a   = `XLEN'(inst_i.sa);
					end
					default: alu_op = ALU_NOP;
				endcase
			end
			default: alu_op = ALU_NOP;
		endcase
	end

	// bubbles, unknown codes and r0 targets write nothing
	assign wen = inst_valid_i && (alu_op != ALU_NOP) && (dest != '0);

	// control under reset, operands just follow
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			id_ex_o.valid  <= 1'b0;
			id_ex_o.alu_op <= ALU_NOP;
			id_ex_o.wen    <= 1'b0;
		end else begin
			id_ex_o.valid  <= inst_valid_i;
			id_ex_o.alu_op <= alu_op;
			id_ex_o.wen    <= wen;
		end
		id_ex_o.op_a <= op_a;
		id_ex_o.op_b <= op_b;
		id_ex_o.dest <= dest;
	end

	// an r0 read would pick up a forwarded value otherwise
	a_fwd_no_r0: assert property (
		@(posedge clk_i) disable iff (rst_i)
		ex_fwd_i.wen |-> (ex_fwd_i.dest != '0)
	);

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none

`include "core_config.svh"

module execute_stage
	import pipe_pkg::*;
(
	input  wire logic   clk_i,
	input  wire logic   rst_i,
	input  wire id_ex_t id_ex_i,
	// same-cycle result for decode bypass
	output wb_t         ex_fwd_o,
	// registered result, goes to reg file and ports
	output wb_t         wb_o
);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [4:0]       shamt;
	logic [`XLEN-1:0] alu_res;

	assign a = id_ex_i.op_a;
	assign b = id_ex_i.op_b;

	// sa or rs, low five bits only
	assign shamt = a[4:0];

	always_comb begin
		case (id_ex_i.alu_op)
			ALU_OR, ALU_ORI: alu_res = a | b;
			ALU_AND, ALU_ANDI: alu_res = a & b;
			ALU_XOR, ALU_XORI: alu_res = a ^ b;
			ALU_NOR: alu_res = ~(a | b);
			// no overflow trap, all adds wrap
			ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU: alu_res = a + b;
			ALU_SUB, ALU_SUBU: alu_res = a - b;
			ALU_SLT: alu_res = `XLEN'($signed(a) < $signed(b));
			ALU_SLTU, ALU_SLTIU: alu_res = `XLEN'(a < b);
			// immediate into the upper half
			ALU_LUI: alu_res = b << 16;
			ALU_SLL, ALU_SLLV: alu_res = b << shamt;
			ALU_SRL, ALU_SRLV: alu_res = b >> shamt;
			ALU_SRA, ALU_SRAV: alu_res = $signed(b) >>> shamt;
			default: alu_res = `ZERO_WORD;
		endcase
	end

	// qualified by valid here so a stale wen never leaks
	assign ex_fwd_o.wen  = id_ex_i.valid && id_ex_i.wen;
	assign ex_fwd_o.dest = id_ex_i.dest;
	assign ex_fwd_o.data = alu_res;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_o.wen <= 1'b0;
		end else begin
			wb_o.wen <= ex_fwd_o.wen;
		end
		wb_o.dest <= ex_fwd_o.dest;
		wb_o.data <= ex_fwd_o.data;
	end

	// decode maps every unknown code to NOP and drops its write
	a_nop_no_write: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(id_ex_i.valid && (id_ex_i.alu_op == ALU_NOP)) |-> !id_ex_i.wen
	);

endmodule

`default_nettype wire

// ==== design/int_core.sv ====
`default_nettype none

`include "core_config.svh"

module int_core
	import pipe_pkg::*;
(
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire logic               inst_valid_i,
	input  wire logic [`INST_W-1:0] inst_i,
	// one pulse per committed register write
	output logic                    wb_valid_o,
	output logic      [`REG_AW-1:0] wb_addr_o,
	output logic      [`XLEN-1:0]   wb_data_o
);

	id_ex_t             id_ex;
	wb_t                ex_fwd;
	wb_t                wb;
	logic [`REG_AW-1:0] rs_addr;
	logic [`REG_AW-1:0] rt_addr;
	logic [`XLEN-1:0]   rs_data;
	logic [`XLEN-1:0]   rt_data;

	// raw word lands on the field struct
	decode_stage decode_stage_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.rs_data_i    (rs_data),
		.rt_data_i    (rt_data),
		.ex_fwd_i     (ex_fwd),
		.wb_fwd_i     (wb),
		.rs_addr_o    (rs_addr),
		.rt_addr_o    (rt_addr),
		.id_ex_o      (id_ex)
	);

	execute_stage execute_stage_inst (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.id_ex_i  (id_ex),
		.ex_fwd_o (ex_fwd),
		.wb_o     (wb)
	);

	// written one edge after wb shows up on the ports
	reg_file reg_file_inst (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wb_i      (wb),
		.rs_addr_i (rs_addr),
		.rt_addr_i (rt_addr),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	assign wb_valid_o = wb.wen;
	assign wb_addr_o  = wb.dest;
	assign wb_data_o  = wb.data;

endmodule

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none

`include "core_config.svh"

package isa_pkg;

	// major opcodes, only the ALU group survives
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// SPECIAL group function codes
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// R-type layout, msb first
	// imm16 of I-type is {rd, sa, funct}
	typedef struct packed {
		opcode_e            opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [4:0]         sa;
		funct_e             funct;
	} inst_fields_t;

endpackage

`default_nettype wire

// ==== design/pipe_pkg.sv ====
`default_nettype none

`include "core_config.svh"

package pipe_pkg;

	// one code per instruction kept in the core
	typedef enum logic [4:0] {
		ALU_NOP,
		ALU_ORI,
		ALU_ANDI,
		ALU_XORI,
		ALU_LUI,
		ALU_ADDI,
		ALU_ADDIU,
		ALU_SLTIU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_ADD,
		ALU_ADDU,
		ALU_SUB,
		ALU_SUBU,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLLV,
		ALU_SRLV,
		ALU_SRAV
	} alu_op_e;

	// decode to execute
	// operands already resolved through bypass
	typedef struct packed {
		logic               valid;
		alu_op_e            alu_op;
		logic [`XLEN-1:0]   op_a;
		logic [`XLEN-1:0]   op_b;
		logic [`REG_AW-1:0] dest;
		logic               wen;
	} id_ex_t;

	// register write, also used as bypass source
	typedef struct packed {
		logic               wen;
		logic [`REG_AW-1:0] dest;
		logic [`XLEN-1:0]   data;
	} wb_t;

endpackage

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

`include "core_config.svh"

module reg_file
	import pipe_pkg::*;
(
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	// write port from writeback stage
	input  wire wb_t                wb_i,
	// read ports addressed by decode
	input  wire logic [`REG_AW-1:0] rs_addr_i,
	input  wire logic [`REG_AW-1:0] rt_addr_i,
	output logic      [`XLEN-1:0]   rs_data_o,
	output logic      [`XLEN-1:0]   rt_data_o
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// whole array cleared on reset
	// r0 never takes a write
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= `ZERO_WORD;
			end
		end else if (wb_i.wen && (wb_i.dest != '0)) begin
			regs[wb_i.dest] <= wb_i.data;
		end
	end

	// async read, r0 hardwired
	// same-cycle write is not seen here, decode bypasses it
	assign rs_data_o = (rs_addr_i == '0) ? `ZERO_WORD : regs[rs_addr_i];
	assign rt_data_o = (rt_addr_i == '0) ? `ZERO_WORD : regs[rt_addr_i];

	// decode drops wen for r0 two stages upstream
	a_no_r0_write: assert property (
		@(posedge clk_i) disable iff (rst_i)
		wb_i.wen |-> (wb_i.dest != '0)
	);

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/int_core.sv
tests/clk_gen.sv
tests/tb_int_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_int_core -f project.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if grep -qx "TB PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi

// ==== tests/clk_gen.sv ====
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// free running, starts low
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// held for the first RESET_CYCLES rising edges
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/tb_int_core.sv ====
`default_nettype none

`include "core_config.svh"

module tb_int_core
	import isa_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD_NS = 20;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_RANDOM = 400;
	// lui + ori for r1..r7
	localparam int NUM_PRELOAD = 14;
	localparam int LIMIT_NS = (RESET_CYCLES + 2 + NUM_PRELOAD + NUM_RANDOM + 20) * PERIOD_NS;

	// one expected register write
	typedef struct packed {
		logic [`REG_AW-1:0] addr;
		logic [`XLEN-1:0]   data;
		logic [31:0]        due;
	} wr_exp_t;

	logic               clk;
	logic               rst;
	logic               inst_valid;
	logic [`INST_W-1:0] inst_word;
	logic               wb_valid;
	logic [`REG_AW-1:0] wb_addr;
	logic [`XLEN-1:0]   wb_data;

	integer             seed = 32'hfa8a2992;
	logic [31:0]        neg_cnt = '0;
	logic [`XLEN-1:0]   mregs [`NUM_REGS];
	wr_exp_t            exp_q [$];

	// 8 slots, addi repeated to fill the last one
	opcode_e     imm_ops [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
		OP_ADDI, OP_ADDIU, OP_SLTIU, OP_ADDI};
	funct_e      spec_fns [16] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
		FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
	// j, beq, slti, lw
	logic [5:0]  bad_ops [4] = '{6'h02, 6'h04, 6'h0a, 6'h23};
	// jr, movz, movn, mult
	logic [5:0]  bad_fns [4] = '{6'h08, 6'h0a, 6'h0b, 6'h18};

	clk_gen #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (RESET_CYCLES)
	) clk_gen_inst (
		.clk_o (clk),
		.rst_o (rst)
	);

	int_core int_core_inst (
		.clk_i        (clk),
		.rst_i        (rst),
		.inst_valid_i (inst_valid),
		.inst_i       (inst_word),
		.wb_valid_o   (wb_valid),
		.wb_addr_o    (wb_addr),
		.wb_data_o    (wb_data)
	);

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			stop_failed($sformatf("[FAIL] %0d ns: %s got %0h expected %0h",
				$time, what, got, exp));
		end
	endtask

	// reference behaviour, results queued in issue order
	task automatic model_issue(input logic [`INST_W-1:0] word, input logic [31:0] due);
		inst_fields_t       f;
		logic [`XLEN-1:0]   a_v;
		logic [`XLEN-1:0]   b_v;
		logic [`XLEN-1:0]   se;
		logic [`XLEN-1:0]   ze;
		logic [`XLEN-1:0]   res;
		logic [`REG_AW-1:0] dest;
		logic               known;
		wr_exp_t            e;
		f = inst_fields_t'(word);
		a_v = mregs[f.rs];
		b_v = mregs[f.rt];
		se = {{16{word[15]}}, word[15:0]};
		ze = {16'h0000, word[15:0]};
		res = '0;
		dest = f.rt;
		known = 1'b1;
		case (f.opcode)
			OP_ORI: res = a_v | ze;
			OP_ANDI: res = a_v & ze;
			OP_XORI: res = a_v ^ ze;
			OP_LUI: res = {word[15:0], 16'h0000};
			// no trap, plain wrap
			OP_ADDI, OP_ADDIU: res = a_v + se;
			OP_SLTIU: res = (a_v < se) ? 32'd1 : 32'd0;
			OP_SPECIAL: begin
				dest = f.rd;
				case (f.funct)
					FN_SLL: res = b_v << f.sa;
					FN_SRL: res = b_v >> f.sa;
					FN_SRA: res = $signed(b_v) >>> f.sa;
					FN_SLLV: res = b_v << a_v[4:0];
					FN_SRLV: res = b_v >> a_v[4:0];
					FN_SRAV: res = $signed(b_v) >>> a_v[4:0];
					FN_ADD, FN_ADDU: res = a_v + b_v;
					FN_SUB, FN_SUBU: res = a_v - b_v;
					FN_AND: res = a_v & b_v;
					FN_OR: res = a_v | b_v;
					FN_XOR: res = a_v ^ b_v;
					FN_NOR: res = ~(a_v | b_v);
					FN_SLT: res = ($signed(a_v) < $signed(b_v)) ? 32'd1 : 32'd0;
					FN_SLTU: res = (a_v < b_v) ? 32'd1 : 32'd0;
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
		// bubbles and r0 targets leave no trace
		if (known && (dest != '0)) begin
			mregs[dest] = res;
			e.addr = dest;
			e.data = res;
			e.due = due;
			exp_q.push_back(e);
		end
	endtask

	// drive on the rising edge, sampled by the DUT one edge later
	task automatic drive_inst(input logic valid, input logic [`INST_W-1:0] word);
		@(posedge clk);
		inst_valid <= valid;
		inst_word <= word;
		// result due at the third falling edge from here
		if (valid) begin
			model_issue(word, neg_cnt + 32'd3);
		end
	endtask

	task automatic rand_inst(output logic valid, output logic [`INST_W-1:0] word);
		logic [31:0]        rnd;
		logic [31:0]        fld;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		rnd = $random(seed);
		fld = $random(seed);
		// r0..r7 keeps dependencies close
		rs = {2'b00, fld[2:0]};
		rt = {2'b00, fld[5:3]};
		rd = {2'b00, fld[8:6]};
		valid = 1'b1;
		if (rnd[3:0] < 4'd6) begin
			word = {imm_ops[rnd[6:4]], rs, rt, fld[31:16]};
		end else if (rnd[3:0] < 4'd12) begin
			word = {OP_SPECIAL, rs, rt, rd, fld[13:9], spec_fns[rnd[7:4]]};
		end else if (rnd[3:0] == 4'd13) begin
			word = {bad_ops[rnd[5:4]], rs, rt, fld[31:16]};
		end else if (rnd[3:0] == 4'd14) begin
			word = {OP_SPECIAL, rs, rt, rd, fld[13:9], bad_fns[rnd[5:4]]};
		end else begin
			// idle slot, garbage on the bus
			valid = 1'b0;
			word = fld;
		end
	endtask

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		wr_exp_t head;
		neg_cnt = neg_cnt + 32'd1;
		if (!rst && wb_valid) begin
			if (exp_q.size() == 0) begin
				stop_failed($sformatf("unexpected write to r%0d at %0d ns", wb_addr, $time));
			end else begin
				head = exp_q.pop_front();
				check_eq(64'(wb_addr), 64'(head.addr), "write address");
				check_eq(64'(wb_data), 64'(head.data), "write data");
				check_eq(64'(neg_cnt), 64'(head.due), "write cycle");
			end
		end
	end

	initial begin
		#(LIMIT_NS);
		stop_failed($sformatf("watchdog expired after %0d ns, run did not finish", LIMIT_NS));
	end

	initial begin
		logic               v;
		logic [`INST_W-1:0] w;
		inst_valid = 1'b0;
		inst_word = '0;
		foreach (mregs[i]) begin
			mregs[i] = '0;
		end
		// quiet through reset and two cycles beyond
		do begin
			@(negedge clk);
			check_eq(64'(wb_valid), 64'd0, "wb_valid in reset");
		end while (rst);
		repeat (2) begin
			@(negedge clk);
			check_eq(64'(wb_valid), 64'd0, "wb_valid after reset");
		end
		// full 32-bit patterns in r1..r7
		for (int r = 1; r < 8; r++) begin
			w = $random(seed);
			drive_inst(1'b1, {OP_LUI, 5'd0, 5'(r), w[31:16]});
			drive_inst(1'b1, {OP_ORI, 5'(r), 5'(r), w[15:0]});
		end
		repeat (NUM_RANDOM) begin
			rand_inst(v, w);
			drive_inst(v, w);
		end
		@(posedge clk);
		inst_valid <= 1'b0;
		// drain, latency is two edges
		repeat (4) @(negedge clk);
		if (exp_q.size() == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			stop_failed($sformatf("%0d expected writes never arrived", exp_q.size()));
		end
	end

endmodule

`default_nettype wire
